/* Bender.yml */
package:
  name: branch_stats

sources:
  - files:
      - hw/branch_stat_pkg.sv
      - hw/stat_axil_pkg.sv
      - hw/stat_read_if.sv
      - hw/branch_event_decoder.sv
      - hw/branch_counter_bank.sv
      - hw/stat_axil_slave.sv
      - hw/branch_stats_top.sv
  - target: test
    files:
      - sim/tb_branch_stats.sv

/* hw/branch_counter_bank.sv */
// Branch statistics counter bank
// Sixteen saturating counters with a clear and an indexed read port

`timescale 1ns/10ps
`default_nettype none

module branch_counter_bank #(
    parameter int unsigned CNT_WIDTH = 32
) (
    input  wire logic                        CLK,
    input  wire logic                        nRST,
    input  wire logic                        inc_valid,
    input  wire branch_stat_pkg::stat_mask_t inc_mask,
    stat_read_if.bank                        stat
);

    typedef logic [CNT_WIDTH-1:0] cnt_t;

    cnt_t cnt [branch_stat_pkg::NUM_STATS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int k = 0; k < branch_stat_pkg::NUM_STATS; k++) begin
                cnt[k] <= '0;
            end
        end else if (stat.clear) begin
            // Clear wins over a same-cycle increment
            for (int k = 0; k < branch_stat_pkg::NUM_STATS; k++) begin
                cnt[k] <= '0;
            end
        end else if (inc_valid) begin
            for (int k = 0; k < branch_stat_pkg::NUM_STATS; k++) begin
                if (inc_mask[k] && (cnt[k] != '1)) begin
                    cnt[k] <= cnt[k] + 1'b1;
                end
            end
        end
    end

    // Combinational read data for the slave to register
    assign stat.rd_data = cnt[stat.rd_idx];

    // Every predicted branch lands in exactly one direction class,
    // so the totals agree until one of them saturates
    a_fb_total : assert property (
        @(posedge CLK) disable iff (!nRST)
        ((cnt[branch_stat_pkg::STAT_PREDICTED] != '1) &&
         (cnt[branch_stat_pkg::STAT_FWD_BRANCH] != '1) &&
         (cnt[branch_stat_pkg::STAT_BWD_BRANCH] != '1)) |->
            ({1'b0, cnt[branch_stat_pkg::STAT_PREDICTED]} ==
             ({1'b0, cnt[branch_stat_pkg::STAT_FWD_BRANCH]} +
              {1'b0, cnt[branch_stat_pkg::STAT_BWD_BRANCH]}))
    );

endmodule : branch_counter_bank

`default_nettype wire

/* hw/branch_event_decoder.sv */
// Branch event decoder
// Registers one core report and turns it into an increment mask

`timescale 1ns/10ps
`default_nettype none

module branch_event_decoder (
    input  wire logic                        CLK,
    input  wire logic                        nRST,
    input  wire logic                        update_predictor,
    input  wire logic                        prediction,
    input  wire logic                        branch_result,
    input  wire logic                        direction,
    input  wire logic                        is_jalr,
    stat_read_if.decoder                     stat,
    output      logic                        inc_valid,
    output      branch_stat_pkg::stat_mask_t inc_mask
);

    branch_stat_pkg::stat_mask_t mask_d;
    logic                        hit;

    assign hit = (prediction == branch_result);

    always_comb begin
        mask_d = '0;
        if (stat.enable) begin
            if (update_predictor) begin
                mask_d[branch_stat_pkg::STAT_PREDICTED]    = 1'b1;
                mask_d[branch_stat_pkg::STAT_CORRECT]      = hit;
                mask_d[branch_stat_pkg::STAT_MISPREDICTED] = !hit;

                mask_d[branch_stat_pkg::STAT_PRED_TAKEN]          = prediction;
                mask_d[branch_stat_pkg::STAT_PRED_NOT_TAKEN]      = !prediction;
                mask_d[branch_stat_pkg::STAT_TAKEN_INCORRECT]     = prediction && !branch_result;
                mask_d[branch_stat_pkg::STAT_NOT_TAKEN_INCORRECT] = !prediction && branch_result;

                // Backward target when direction is set
                if (direction) begin
                    mask_d[branch_stat_pkg::STAT_BWD_BRANCH]     = 1'b1;
                    mask_d[branch_stat_pkg::STAT_BWD_PRED_TAKEN] = prediction;
                    mask_d[branch_stat_pkg::STAT_BWD_TAKEN_CORRECT] =
                        prediction && branch_result;
                    mask_d[branch_stat_pkg::STAT_BWD_NOT_TAKEN_CORRECT] =
                        !prediction && !branch_result;
                end else begin
                    mask_d[branch_stat_pkg::STAT_FWD_BRANCH]     = 1'b1;
                    mask_d[branch_stat_pkg::STAT_FWD_PRED_TAKEN] = prediction;
                    mask_d[branch_stat_pkg::STAT_FWD_TAKEN_CORRECT] =
                        prediction && branch_result;
                    mask_d[branch_stat_pkg::STAT_FWD_NOT_TAKEN_CORRECT] =
                        !prediction && !branch_result;
                end
            end
            // jalr counts on its own with or without a branch report
            mask_d[branch_stat_pkg::STAT_UNCONDITIONAL] = is_jalr;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            inc_valid <= 1'b0;
            inc_mask  <= '0;
        end else begin
            inc_valid <= |mask_d;
            inc_mask  <= mask_d;
        end
    end

    // An enabled report yields one verdict and one direction in the next cycle
    a_pred_verdict : assert property (
        @(posedge CLK) disable iff (!nRST)
        (stat.enable && update_predictor) |=>
            inc_mask[branch_stat_pkg::STAT_PREDICTED] &&
            $onehot({inc_mask[branch_stat_pkg::STAT_CORRECT],
                     inc_mask[branch_stat_pkg::STAT_MISPREDICTED]})
    );

    a_pred_direction : assert property (
        @(posedge CLK) disable iff (!nRST)
        (stat.enable && update_predictor) |=>
            $onehot({inc_mask[branch_stat_pkg::STAT_FWD_BRANCH],
                     inc_mask[branch_stat_pkg::STAT_BWD_BRANCH]})
    );

endmodule : branch_event_decoder

`default_nettype wire

/* hw/branch_stat_pkg.sv */
// Branch statistics definitions
// Event class indices, the increment mask and the class count

`default_nettype none

package branch_stat_pkg;

    // One counter per event class
    localparam int unsigned NUM_STATS = 16;

    // Class order is also the counter order in the register map
    typedef enum logic [3:0] {
        STAT_UNCONDITIONAL         = 4'd0,
        STAT_PREDICTED             = 4'd1,
        STAT_MISPREDICTED          = 4'd2,
        STAT_CORRECT               = 4'd3,
        STAT_PRED_TAKEN            = 4'd4,
        STAT_PRED_NOT_TAKEN        = 4'd5,
        STAT_TAKEN_INCORRECT       = 4'd6,
        STAT_NOT_TAKEN_INCORRECT   = 4'd7,
        STAT_FWD_BRANCH            = 4'd8,
        STAT_FWD_PRED_TAKEN        = 4'd9,
        STAT_FWD_TAKEN_CORRECT     = 4'd10,
        STAT_FWD_NOT_TAKEN_CORRECT = 4'd11,
        STAT_BWD_BRANCH            = 4'd12,
        STAT_BWD_PRED_TAKEN        = 4'd13,
        STAT_BWD_TAKEN_CORRECT     = 4'd14,
        STAT_BWD_NOT_TAKEN_CORRECT = 4'd15
    } stat_idx_e;

    // A set bit increments its class
    typedef logic [NUM_STATS-1:0] stat_mask_t;

endpackage : branch_stat_pkg

`default_nettype wire

/* hw/branch_stats_top.sv */
// Branch prediction statistics unit
// Counts resolved branch events and exposes the counters over AXI4-Lite

`timescale 1ns/10ps
`default_nettype none

module branch_stats_top #(
    parameter int unsigned CNT_WIDTH = 32
) (
    input  wire logic                      CLK,
    input  wire logic                      nRST,
    // Core report
    input  wire logic                      update_predictor,
    input  wire logic                      prediction,
    input  wire logic                      branch_result,
    input  wire logic                      direction,
    input  wire logic                      is_jalr,
    // AXI4-Lite host port
    input  wire stat_axil_pkg::axil_addr_t AWADDR,
    input  wire logic                      AWVALID,
    output      logic                      AWREADY,
    input  wire stat_axil_pkg::axil_data_t WDATA,
    input  wire logic [3:0]                WSTRB,
    input  wire logic                      WVALID,
    output      logic                      WREADY,
    output      stat_axil_pkg::axil_resp_t BRESP,
    output      logic                      BVALID,
    input  wire logic                      BREADY,
    input  wire stat_axil_pkg::axil_addr_t ARADDR,
    input  wire logic                      ARVALID,
    output      logic                      ARREADY,
    output      stat_axil_pkg::axil_data_t RDATA,
    output      stat_axil_pkg::axil_resp_t RRESP,
    output      logic                      RVALID,
    input  wire logic                      RREADY
);

    logic                        inc_valid;
    branch_stat_pkg::stat_mask_t inc_mask;

    stat_read_if #(.CNT_WIDTH(CNT_WIDTH)) stat_if ();

    branch_event_decoder branch_event_decoder_i (
        .CLK              (CLK),
        .nRST             (nRST),
        .update_predictor (update_predictor),
        .prediction       (prediction),
        .branch_result    (branch_result),
        .direction        (direction),
        .is_jalr          (is_jalr),
        .stat             (stat_if.decoder),
        .inc_valid        (inc_valid),
        .inc_mask         (inc_mask)
    );

    branch_counter_bank #(
        .CNT_WIDTH (CNT_WIDTH)
    ) branch_counter_bank_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .inc_valid (inc_valid),
        .inc_mask  (inc_mask),
        .stat      (stat_if.bank)
    );

    stat_axil_slave stat_axil_slave_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .AWADDR  (AWADDR),
        .AWVALID (AWVALID),
        .AWREADY (AWREADY),
        .WDATA   (WDATA),
        .WSTRB   (WSTRB),
        .WVALID  (WVALID),
        .WREADY  (WREADY),
        .BRESP   (BRESP),
        .BVALID  (BVALID),
        .BREADY  (BREADY),
        .ARADDR  (ARADDR),
        .ARVALID (ARVALID),
        .ARREADY (ARREADY),
        .RDATA   (RDATA),
        .RRESP   (RRESP),
        .RVALID  (RVALID),
        .RREADY  (RREADY),
        .stat    (stat_if.slave)
    );

endmodule : branch_stats_top

`default_nettype wire

/* hw/stat_axil_pkg.sv */
// AXI4-Lite register map for the branch statistics unit
// Bus types, response codes and channel states

`default_nettype none

package stat_axil_pkg;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Counter k lives at STAT_BASE + 4*k
    localparam axil_addr_t STAT_BASE = 8'h00;
    localparam axil_addr_t CTRL_ADDR = 8'h40;

    // Control register bits
    localparam int unsigned CTRL_ENABLE_BIT = 0;
    localparam int unsigned CTRL_CLEAR_BIT  = 1;

    // Shared by the write and the read channel FSMs
    typedef enum logic {
        IDLE = 1'b0,
        RESP = 1'b1
    } axil_state_e;

endpackage : stat_axil_pkg

`default_nettype wire

/* hw/stat_axil_slave.sv */
// AXI4-Lite slave for the branch statistics unit
// Decodes the register map, holds the control register, returns counters

`timescale 1ns/10ps
`default_nettype none

module stat_axil_slave (
    input  wire logic                      CLK,
    input  wire logic                      nRST,
    input  wire stat_axil_pkg::axil_addr_t AWADDR,
    input  wire logic                      AWVALID,
    output      logic                      AWREADY,
    input  wire stat_axil_pkg::axil_data_t WDATA,
    input  wire logic [3:0]                WSTRB,
    input  wire logic                      WVALID,
    output      logic                      WREADY,
    output      stat_axil_pkg::axil_resp_t BRESP,
    output      logic                      BVALID,
    input  wire logic                      BREADY,
    input  wire stat_axil_pkg::axil_addr_t ARADDR,
    input  wire logic                      ARVALID,
    output      logic                      ARREADY,
    output      stat_axil_pkg::axil_data_t RDATA,
    output      stat_axil_pkg::axil_resp_t RRESP,
    output      logic                      RVALID,
    input  wire logic                      RREADY,
    stat_read_if.slave                     stat
);

    stat_axil_pkg::axil_state_e wr_state;
    stat_axil_pkg::axil_state_e rd_state;
    stat_axil_pkg::axil_addr_t  rd_off;

    logic wr_hs;
    logic rd_hs;
    logic wr_is_ctrl;
    logic ctrl_lane;
    logic rd_is_cnt;
    logic rd_is_ctrl;

    // Address and data are taken together while no response is pending
    assign wr_hs   = (wr_state == stat_axil_pkg::IDLE) && AWVALID && WVALID;
    assign AWREADY = wr_hs;
    assign WREADY  = wr_hs;
    assign BVALID  = (wr_state == stat_axil_pkg::RESP);

    assign ARREADY = (rd_state == stat_axil_pkg::IDLE);
    assign RVALID  = (rd_state == stat_axil_pkg::RESP);
    assign rd_hs   = ARREADY && ARVALID;

    assign wr_is_ctrl = (AWADDR == stat_axil_pkg::CTRL_ADDR);
    assign ctrl_lane  = WSTRB[0];
    assign rd_is_ctrl = (ARADDR == stat_axil_pkg::CTRL_ADDR);

    // Word aligned counter window
    assign rd_off      = ARADDR - stat_axil_pkg::STAT_BASE;
    assign rd_is_cnt   = (rd_off[1:0] == 2'b00) &&
                         (rd_off[7:2] < 6'(branch_stat_pkg::NUM_STATS));
    assign stat.rd_idx = branch_stat_pkg::stat_idx_e'(rd_off[5:2]);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_state    <= stat_axil_pkg::IDLE;
            rd_state    <= stat_axil_pkg::IDLE;
            stat.enable <= 1'b1;
            stat.clear  <= 1'b0;
        end else begin
            stat.clear <= 1'b0;
            if (wr_hs) begin
                wr_state <= stat_axil_pkg::RESP;
                if (wr_is_ctrl && ctrl_lane) begin
                    stat.enable <= WDATA[stat_axil_pkg::CTRL_ENABLE_BIT];
                    stat.clear  <= WDATA[stat_axil_pkg::CTRL_CLEAR_BIT];
                end
            end else if (BVALID && BREADY) begin
                wr_state <= stat_axil_pkg::IDLE;
            end

            if (rd_hs) begin
                rd_state <= stat_axil_pkg::RESP;
            end else if (RVALID && RREADY) begin
                rd_state <= stat_axil_pkg::IDLE;
            end
        end
    end

    // Response payload is loaded only on a handshake
    always_ff @(posedge CLK) begin
        if (wr_hs) begin
            BRESP <= wr_is_ctrl ? stat_axil_pkg::RESP_OKAY : stat_axil_pkg::RESP_SLVERR;
        end
        if (rd_hs) begin
            if (rd_is_cnt) begin
                RDATA <= stat_axil_pkg::axil_data_t'(stat.rd_data);
                RRESP <= stat_axil_pkg::RESP_OKAY;
            end else if (rd_is_ctrl) begin
                RDATA <= '0;
                RDATA[stat_axil_pkg::CTRL_ENABLE_BIT] <= stat.enable;
                RRESP <= stat_axil_pkg::RESP_OKAY;
            end else begin
                RDATA <= '0;
                RRESP <= stat_axil_pkg::RESP_SLVERR;
            end
        end
    end

    a_r_stable : assert property (
        @(posedge CLK) disable iff (!nRST)
        (RVALID && !RREADY) |=> (RVALID && $stable(RDATA) && $stable(RRESP))
    );

    a_b_hold : assert property (
        @(posedge CLK) disable iff (!nRST)
        (BVALID && !BREADY) |=> BVALID
    );

endmodule : stat_axil_slave

`default_nettype wire

/* hw/stat_read_if.sv */
// Counter access link between the AXI4-Lite slave and the counter bank
// Carries the read index and data, the clear pulse and the enable bit

`timescale 1ns/10ps
`default_nettype none

interface stat_read_if #(
    parameter int unsigned CNT_WIDTH = 32
);

    branch_stat_pkg::stat_idx_e rd_idx;
    logic [CNT_WIDTH-1:0]       rd_data;
    logic                       clear;
    logic                       enable;

    modport slave (
        output rd_idx, clear, enable,
        input  rd_data
    );

    modport bank (
        input  rd_idx, clear,
        output rd_data
    );

    // Only the decoder gates on enable
    modport decoder (
        input enable
    );

endinterface : stat_read_if

`default_nettype wire

/* list.f */
hw/branch_stat_pkg.sv
hw/stat_axil_pkg.sv
hw/stat_read_if.sv
hw/branch_event_decoder.sv
hw/branch_counter_bank.sv
hw/stat_axil_slave.sv
hw/branch_stats_top.sv
sim/tb_branch_stats.sv

/* sim/tb_branch_stats.sv */
// Testbench for the branch prediction statistics unit
// Random branch traffic against a reference model, counters read over AXI4-Lite

`timescale 1ns/10ps
`default_nettype none

module tb_branch_stats;

    localparam int TIMEOUT_CYCLES = 100;

    typedef logic [branch_stat_pkg::NUM_STATS-1:0][31:0] model_t;

    logic CLK = 1'b0;
    logic nRST;
    logic update_predictor, prediction, branch_result, direction, is_jalr;
    stat_axil_pkg::axil_addr_t AWADDR, ARADDR;
    stat_axil_pkg::axil_data_t WDATA, RDATA;
    stat_axil_pkg::axil_resp_t BRESP, RRESP;
    logic [3:0] WSTRB;
    logic AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
    logic ARVALID, ARREADY, RVALID, RREADY;

    model_t model;
    logic   model_enable;
    int     error_count;

    branch_stats_top #(.CNT_WIDTH(32)) branch_stats_top_i (.*);

    always #10 CLK = ~CLK;

    // Expected counters after one report
    function automatic model_t predict_counters(input model_t cnt, input logic upd,
                                                input logic pred, input logic res,
                                                input logic dir, input logic jalr,
                                                input logic en);
        model_t                      nxt;
        branch_stat_pkg::stat_mask_t hits;
        int                          base;
        hits = '0;
        base = dir ? int'(branch_stat_pkg::STAT_BWD_BRANCH)
                   : int'(branch_stat_pkg::STAT_FWD_BRANCH);
        if (en && upd) begin
            hits[branch_stat_pkg::STAT_PREDICTED]           = 1'b1;
            hits[branch_stat_pkg::STAT_CORRECT]             = (pred == res);
            hits[branch_stat_pkg::STAT_MISPREDICTED]        = (pred != res);
            hits[branch_stat_pkg::STAT_PRED_TAKEN]          = pred;
            hits[branch_stat_pkg::STAT_PRED_NOT_TAKEN]      = !pred;
            hits[branch_stat_pkg::STAT_TAKEN_INCORRECT]     = pred && !res;
            hits[branch_stat_pkg::STAT_NOT_TAKEN_INCORRECT] = !pred && res;
            // Forward and backward groups share the same layout
            hits[base]     = 1'b1;
            hits[base + 1] = pred;
            hits[base + 2] = pred && res;
            hits[base + 3] = !pred && !res;
        end
        hits[branch_stat_pkg::STAT_UNCONDITIONAL] = en && jalr;
        nxt = cnt;
        for (int k = 0; k < branch_stat_pkg::NUM_STATS; k++) begin
            if (hits[k] && (cnt[k] != '1)) begin
                nxt[k] = cnt[k] + 1;
            end
        end
        return nxt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("No %s from the DUT within %0d cycles", what, TIMEOUT_CYCLES);
        $display("Verification failed");
        $fatal(1, "Handshake timeout");
    endtask

    task automatic axil_write(input stat_axil_pkg::axil_addr_t addr,
                              input stat_axil_pkg::axil_data_t data, input logic [3:0] strb,
                              input int stall, output stat_axil_pkg::axil_resp_t resp);
        int n;
        @(posedge CLK);
        #2;
        AWADDR  = addr;
        WDATA   = data;
        WSTRB   = strb;
        AWVALID = 1'b1;
        WVALID  = 1'b1;
        n = 0;
        @(negedge CLK);
        while (!(AWREADY && WREADY)) begin
            n++;
            if (n >= TIMEOUT_CYCLES) fail_timeout("AWREADY and WREADY");
            @(negedge CLK);
        end
        @(posedge CLK);
        #2;
        AWVALID = 1'b0;
        WVALID  = 1'b0;
        n = 0;
        @(negedge CLK);
        while (!BVALID) begin
            n++;
            if (n >= TIMEOUT_CYCLES) fail_timeout("BVALID");
            @(negedge CLK);
        end
        resp = BRESP;
        // BVALID has to stay up while BREADY is held low
        repeat (stall) begin
            @(negedge CLK);
            check_value("BVALID", BVALID, 1);
        end
        @(posedge CLK);
        #2;
        BREADY = 1'b1;
        @(posedge CLK);
        #2;
        BREADY = 1'b0;
        check_value("BVALID", BVALID, 0);
    endtask

    task automatic axil_read(input stat_axil_pkg::axil_addr_t addr, input int stall,
                             output stat_axil_pkg::axil_data_t data,
                             output stat_axil_pkg::axil_resp_t resp);
        int n;
        @(posedge CLK);
        #2;
        ARADDR  = addr;
        ARVALID = 1'b1;
        n = 0;
        @(negedge CLK);
        while (!ARREADY) begin
            n++;
            if (n >= TIMEOUT_CYCLES) fail_timeout("ARREADY");
            @(negedge CLK);
        end
        @(posedge CLK);
        #2;
        ARVALID = 1'b0;
        n = 0;
        @(negedge CLK);
        while (!RVALID) begin
            n++;
            if (n >= TIMEOUT_CYCLES) fail_timeout("RVALID");
            @(negedge CLK);
        end
        data = RDATA;
        resp = RRESP;
        repeat (stall) begin
            @(negedge CLK);
            check_value("RVALID", RVALID, 1);
            check_value("RDATA", RDATA, data);
        end
        @(posedge CLK);
        #2;
        RREADY = 1'b1;
        @(posedge CLK);
        #2;
        RREADY = 1'b0;
        check_value("RVALID", RVALID, 0);
    endtask

    task automatic run_traffic(input int cycles);
        repeat (cycles) begin
            @(posedge CLK);
            #2;
            update_predictor = $urandom_range(0, 1);
            prediction       = $urandom_range(0, 1);
            branch_result    = $urandom_range(0, 1);
            direction        = $urandom_range(0, 1);
            is_jalr          = $urandom_range(0, 1);
            model = predict_counters(model, update_predictor, prediction, branch_result,
                                     direction, is_jalr, model_enable);
        end
        @(posedge CLK);
        #2;
        update_predictor = 1'b0;
        is_jalr          = 1'b0;
        // Last report needs two more edges to reach the counters
        repeat (2) @(posedge CLK);
    endtask

    task automatic check_counters(input int max_stall);
        stat_axil_pkg::axil_data_t data;
        stat_axil_pkg::axil_resp_t resp;
        for (int k = 0; k < branch_stat_pkg::NUM_STATS; k++) begin
            axil_read(stat_axil_pkg::STAT_BASE + 8'(4 * k), $urandom_range(0, max_stall),
                      data, resp);
            check_value($sformatf("RDATA[counter %0d]", k), data, model[k]);
            check_value("RRESP", 32'(resp), 32'(stat_axil_pkg::RESP_OKAY));
        end
    endtask

    task automatic check_ctrl(input logic [31:0] exp);
        stat_axil_pkg::axil_data_t data;
        stat_axil_pkg::axil_resp_t resp;
        axil_read(stat_axil_pkg::CTRL_ADDR, 0, data, resp);
        check_value("RDATA[ctrl]", data, exp);
        check_value("RRESP", 32'(resp), 32'(stat_axil_pkg::RESP_OKAY));
    endtask

    task automatic write_expect(input stat_axil_pkg::axil_addr_t addr,
                                input stat_axil_pkg::axil_data_t data, input int stall,
                                input stat_axil_pkg::axil_resp_t exp);
        stat_axil_pkg::axil_resp_t resp;
        axil_write(addr, data, 4'hF, stall, resp);
        check_value($sformatf("BRESP[0x%02h]", addr), 32'(resp), 32'(exp));
    endtask

    initial begin
        stat_axil_pkg::axil_addr_t bad_rd [5];
        stat_axil_pkg::axil_data_t data;
        stat_axil_pkg::axil_resp_t resp;
        void'($urandom(16957));
        bad_rd = '{8'h44, 8'h48, 8'h80, 8'h02, 8'hFC};
        nRST = 1'b0;
        {update_predictor, prediction, branch_result, direction, is_jalr} = '0;
        {AWADDR, ARADDR, WDATA, WSTRB} = '0;
        {AWVALID, WVALID, BREADY, ARVALID, RREADY} = '0;
        model        = '0;
        model_enable = 1'b1;
        error_count  = 0;
        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;

        // Reset state
        check_value("AWREADY", AWREADY, 0);
        check_value("WREADY", WREADY, 0);
        check_value("BVALID", BVALID, 0);
        check_value("ARREADY", ARREADY, 1);
        check_value("RVALID", RVALID, 0);
        check_counters(0);
        check_ctrl(1);

        run_traffic(500);
        check_counters(0);

        // Counting off and back on
        write_expect(stat_axil_pkg::CTRL_ADDR, 32'h0, 0, stat_axil_pkg::RESP_OKAY);
        model_enable = 1'b0;
        check_ctrl(0);
        run_traffic(200);
        check_counters(0);
        write_expect(stat_axil_pkg::CTRL_ADDR, 32'h1, 0, stat_axil_pkg::RESP_OKAY);
        model_enable = 1'b1;
        run_traffic(200);
        check_counters(0);

        // Clear with enable kept set
        write_expect(stat_axil_pkg::CTRL_ADDR, 32'h3, 0, stat_axil_pkg::RESP_OKAY);
        model = '0;
        check_counters(0);
        check_ctrl(1);
        run_traffic(300);

        // Unmapped reads and writes to read-only counters
        foreach (bad_rd[i]) begin
            axil_read(bad_rd[i], 0, data, resp);
            check_value($sformatf("RDATA[0x%02h]", bad_rd[i]), data, 0);
            check_value("RRESP", 32'(resp), 32'(stat_axil_pkg::RESP_SLVERR));
        end
        write_expect(8'h00, 32'hFFFF_FFFF, 0, stat_axil_pkg::RESP_SLVERR);
        write_expect(8'h3C, 32'h0000_1234, 0, stat_axil_pkg::RESP_SLVERR);
        write_expect(8'h80, 32'h0000_0003, 0, stat_axil_pkg::RESP_SLVERR);
        check_counters(0);

        // Back-pressure on R and B
        run_traffic(300);
        check_counters(8);
        write_expect(stat_axil_pkg::CTRL_ADDR, 32'h1, $urandom_range(1, 8),
                     stat_axil_pkg::RESP_OKAY);
        write_expect(8'h10, 32'h0, $urandom_range(1, 8), stat_axil_pkg::RESP_SLVERR);
        check_counters(8);

        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_branch_stats

`default_nettype wire
